/* design/gat_pkg.sv */
package gat_pkg;

  // ========================================
  // Data widths
  // ========================================
  localparam int DATA_WIDTH     = 8;
  localparam int COL_W          = 4;
  localparam int NODE_WORD_W    = COL_W + DATA_WIDTH;
  localparam int ROW_LEN_W      = 5;
  localparam int OUT_WIDTH      = 24;

  // ========================================
  // Feature counts
  // ========================================
  localparam int NUM_FEAT_IN    = 16;
  localparam int NUM_FEAT_OUT   = 4;
  localparam int NUM_FEAT_FINAL = 2;

  // ReLU upper clamp of a first-layer feature
  localparam int FEAT_MAX       = 4095;

  // ========================================
  // Weight memory
  // ========================================
  // First matrix at in * 4 + out, second at 64 + feat * 2 + final
  localparam int W1_BITS        = NUM_FEAT_IN * NUM_FEAT_OUT * DATA_WIDTH;
  localparam int W2_BITS        = NUM_FEAT_OUT * NUM_FEAT_FINAL * DATA_WIDTH;
  localparam int WGT_DEPTH      = (W1_BITS + W2_BITS) / DATA_WIDTH;
  localparam int WGT_ADDR_W     = 7;

  // Shared node memory word
  // Sparse rows use the col/val view, layer-one features use the flat view
  typedef union packed {
    struct packed {
      logic [COL_W-1:0]             col;
      logic signed [DATA_WIDTH-1:0] val;
    } sparse;
    logic [NODE_WORD_W-1:0] feat;
  } node_word_u;

endpackage

/* design/weight_scheduler.sv */
module weight_scheduler
  import gat_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wgt_wr_en_i,
  input  logic [WGT_ADDR_W-1:0] wgt_addr_i,
  input  logic [DATA_WIDTH-1:0] wgt_data_i,
  input  logic                  wgt_load_done_i,
  output logic                  sched_rdy_o,
  output logic [W1_BITS-1:0]    w1_o,
  output logic [W2_BITS-1:0]    w2_o
);

  localparam int W1_WORDS = W1_BITS / DATA_WIDTH;

  logic [DATA_WIDTH-1:0] wgt_mem [WGT_DEPTH];
  logic [DATA_WIDTH-1:0] rd_data;
  logic [WGT_ADDR_W-1:0] rd_addr;
  logic [WGT_ADDR_W-1:0] wr_slot;
  logic                  running;
  logic                  rd_vld;

  // Host write port, sweep read port
  always_ff @(posedge clk) begin
    if (wgt_wr_en_i) begin
      wgt_mem[wgt_addr_i] <= wgt_data_i;
    end
    if (running) begin
      rd_data <= wgt_mem[rd_addr];
    end
  end

  // ========================================
  // Sweep control
  // ========================================
  // rd_addr parks at WGT_DEPTH after the sweep, so it runs once per reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      running     <= 1'b0;
      rd_vld      <= 1'b0;
      rd_addr     <= '0;
      wr_slot     <= '0;
      sched_rdy_o <= 1'b0;
    end else begin
      rd_vld  <= running;
      wr_slot <= rd_addr;
      if (running) begin
        rd_addr <= rd_addr + 1'b1;
        if (rd_addr == WGT_ADDR_W'(WGT_DEPTH - 1)) begin
          running <= 1'b0;
        end
      end else if (wgt_load_done_i && rd_addr == '0) begin
        running <= 1'b1;
      end
      if (rd_vld && wr_slot == WGT_ADDR_W'(WGT_DEPTH - 1)) begin
        sched_rdy_o <= 1'b1;
      end
    end
  end

  // Unpack each returned word into its matrix slot
  always_ff @(posedge clk) begin
    if (rd_vld) begin
      if (int'(wr_slot) < W1_WORDS) begin
        w1_o[int'(wr_slot) * DATA_WIDTH +: DATA_WIDTH] <= rd_data;
      end else begin
        w2_o[(int'(wr_slot) - W1_WORDS) * DATA_WIDTH +: DATA_WIDTH] <= rd_data;
      end
    end
  end

endmodule

/* design/node_mem_arbiter.sv */
module node_mem_arbiter
  import gat_pkg::*;
#(
  parameter int NUM_NODES   = 8,
  parameter int NNZ_DEPTH   = 64,
  localparam int NODE_DEPTH  = NNZ_DEPTH + NUM_NODES * NUM_FEAT_OUT,
  localparam int NODE_ADDR_W = $clog2(NODE_DEPTH),
  localparam int FEAT_ADDR_W = $clog2(NUM_NODES * NUM_FEAT_OUT)
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   h_wr_en_i,
  input  logic [NODE_ADDR_W-1:0] h_addr_i,
  input  logic [NODE_WORD_W-1:0] h_data_i,
  input  logic [NODE_ADDR_W-1:0] l1_rd_addr_i,
  input  logic                   l1_wr_en_i,
  input  logic [NODE_ADDR_W-1:0] l1_wr_addr_i,
  input  node_word_u             l1_wr_data_i,
  input  logic                   l1_done_i,
  input  logic [FEAT_ADDR_W-1:0] l2_rd_addr_i,
  output node_word_u             node_rd_data_o
);

  node_word_u             node_mem [NODE_DEPTH];
  logic                   layer_q;
  logic [NODE_ADDR_W-1:0] rd_addr;
  logic                   wr_en;
  logic [NODE_ADDR_W-1:0] wr_addr;
  node_word_u             wr_data;

  // Layer flag, set once layer one has stored its features
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      layer_q <= 1'b0;
    end else if (l1_done_i) begin
      layer_q <= 1'b1;
    end
  end

  // ========================================
  // Port muxing
  // ========================================
  // Dense engine addresses the feature region only
  assign rd_addr = layer_q ? NODE_ADDR_W'(NNZ_DEPTH + int'(l2_rd_addr_i)) : l1_rd_addr_i;

  always_comb begin
    wr_en   = 1'b0;
    wr_addr = l1_wr_addr_i;
    wr_data = l1_wr_data_i;
    if (!layer_q) begin
      if (h_wr_en_i) begin
        wr_en   = 1'b1;
        wr_addr = h_addr_i;
        wr_data = h_data_i;
      end else if (l1_wr_en_i) begin
        wr_en = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      node_mem[wr_addr] <= wr_data;
    end
    node_rd_data_o <= node_mem[rd_addr];
  end

  // Host loading is over before layer one writes back
  a_no_wr_clash: assert property (@(posedge clk) disable iff (!rst_n)
    !(h_wr_en_i && l1_wr_en_i));

  a_single_done: assert property (@(posedge clk) disable iff (!rst_n)
    l1_done_i |-> !layer_q);

endmodule

/* design/sparse_layer_engine.sv */
module sparse_layer_engine
  import gat_pkg::*;
#(
  parameter int NUM_NODES   = 8,
  parameter int NNZ_DEPTH   = 64,
  localparam int NODE_DEPTH  = NNZ_DEPTH + NUM_NODES * NUM_FEAT_OUT,
  localparam int NODE_ADDR_W = $clog2(NODE_DEPTH),
  localparam int NODE_IDX_W  = $clog2(NUM_NODES)
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   node_wr_en_i,
  input  logic [NODE_IDX_W-1:0]  node_addr_i,
  input  logic [ROW_LEN_W-1:0]   node_len_i,
  input  logic                   h_load_done_i,
  input  logic                   sched_rdy_i,
  input  logic [W1_BITS-1:0]     w1_i,
  input  node_word_u             node_rd_data_i,
  output logic [NODE_ADDR_W-1:0] l1_rd_addr_o,
  output logic                   l1_wr_en_o,
  output logic [NODE_ADDR_W-1:0] l1_wr_addr_o,
  output node_word_u             l1_wr_data_o,
  output logic                   l1_done_o
);

  localparam int ACC_W     = 2 * DATA_WIDTH + $clog2(NUM_FEAT_IN) + 1;
  localparam int OUT_IDX_W = $clog2(NUM_FEAT_OUT);

  localparam logic [2:0] S_IDLE  = 3'd0;
  localparam logic [2:0] S_INFO  = 3'd1;
  localparam logic [2:0] S_LEN   = 3'd2;
  localparam logic [2:0] S_ENTRY = 3'd3;
  localparam logic [2:0] S_DRAIN = 3'd4;
  localparam logic [2:0] S_WRITE = 3'd5;
  localparam logic [2:0] S_DONE  = 3'd6;

  logic [ROW_LEN_W-1:0]         info_mem [NUM_NODES];
  logic [ROW_LEN_W-1:0]         info_len;
  logic [2:0]                   state;
  logic [NODE_IDX_W-1:0]        node_idx;
  logic [ROW_LEN_W-1:0]         remaining;
  logic [NODE_ADDR_W-1:0]       ptr;
  logic [OUT_IDX_W-1:0]         out_idx;
  logic                         ent_vld;
  logic                         last_node;
  logic signed [DATA_WIDTH-1:0] col_wgt [NUM_FEAT_OUT];
  logic signed [ACC_W-1:0]      acc [NUM_FEAT_OUT];

  function automatic logic [NODE_WORD_W-1:0] relu_clamp(input logic signed [ACC_W-1:0] a);
    if (a < 0) begin
      return '0;
    end else if (a > FEAT_MAX) begin
      return NODE_WORD_W'(FEAT_MAX);
    end
    return a[NODE_WORD_W-1:0];
  endfunction

  // Node-info memory, row length per node
  always_ff @(posedge clk) begin
    if (node_wr_en_i) begin
      info_mem[node_addr_i] <= node_len_i;
    end
    info_len <= info_mem[node_idx];
  end

  assign last_node = (node_idx == NODE_IDX_W'(NUM_NODES - 1));

  // ========================================
  // Row walker
  // ========================================
  // ptr keeps running across nodes, rows are packed back to back
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      node_idx  <= '0;
      remaining <= '0;
      ptr       <= '0;
      out_idx   <= '0;
      ent_vld   <= 1'b0;
      l1_done_o <= 1'b0;
    end else begin
      ent_vld   <= (state == S_ENTRY);
      l1_done_o <= 1'b0;
      case (state)
        S_IDLE: begin
          if (h_load_done_i && sched_rdy_i) begin
            state <= S_INFO;
          end
        end
        S_INFO: state <= S_LEN;
        S_LEN: begin
          remaining <= info_len;
          state     <= (info_len == '0) ? S_WRITE : S_ENTRY;
        end
        S_ENTRY: begin
          ptr       <= ptr + 1'b1;
          remaining <= remaining - 1'b1;
          if (remaining == ROW_LEN_W'(1)) begin
            state <= S_DRAIN;
          end
        end
        S_DRAIN: state <= S_WRITE;
        S_WRITE: begin
          out_idx <= out_idx + 1'b1;
          if (out_idx == OUT_IDX_W'(NUM_FEAT_OUT - 1)) begin
            if (last_node) begin
              state     <= S_DONE;
              l1_done_o <= 1'b1;
            end else begin
              node_idx <= node_idx + 1'b1;
              state    <= S_INFO;
            end
          end
        end
        default: ;
      endcase
    end
  end

  // Weight row picked by the column of the returning entry
  always_comb begin
    int base;
    base = int'(node_rd_data_i.sparse.col) * NUM_FEAT_OUT;
    for (int o = 0; o < NUM_FEAT_OUT; o++) begin
      col_wgt[o] = w1_i[(base + o) * DATA_WIDTH +: DATA_WIDTH];
    end
  end

  always_ff @(posedge clk) begin
    for (int o = 0; o < NUM_FEAT_OUT; o++) begin
      if (state == S_LEN) begin
        acc[o] <= '0;
      end else if (ent_vld) begin
        acc[o] <= acc[o] + node_rd_data_i.sparse.val * col_wgt[o];
      end
    end
  end

  // ========================================
  // Feature write-back
  // ========================================
  assign l1_rd_addr_o = ptr;
  assign l1_wr_en_o   = (state == S_WRITE);
  assign l1_wr_addr_o = NODE_ADDR_W'(NNZ_DEPTH + int'(node_idx) * NUM_FEAT_OUT + int'(out_idx));

  always_comb begin
    l1_wr_data_o.feat = relu_clamp(acc[out_idx]);
  end

  // Host supplies rows no longer than the input width
  a_row_len: assert property (@(posedge clk) disable iff (!rst_n)
    (state == S_LEN) |-> (info_len <= ROW_LEN_W'(NUM_FEAT_IN)));

endmodule

/* design/dense_layer_engine.sv */
module dense_layer_engine
  import gat_pkg::*;
#(
  parameter int NUM_NODES   = 8,
  localparam int NODE_IDX_W  = $clog2(NUM_NODES),
  localparam int FEAT_ADDR_W = $clog2(NUM_NODES * NUM_FEAT_OUT),
  localparam int OUT_DEPTH   = NUM_NODES * NUM_FEAT_FINAL,
  localparam int OUT_ADDR_W  = $clog2(OUT_DEPTH)
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   l1_done_i,
  input  logic [W2_BITS-1:0]     w2_i,
  input  node_word_u             node_rd_data_i,
  input  logic [OUT_ADDR_W-1:0]  feat_rd_addr_i,
  output logic [FEAT_ADDR_W-1:0] l2_rd_addr_o,
  output logic                   gat_ready_o,
  output logic [OUT_WIDTH-1:0]   feat_rd_data_o
);

  localparam int FEAT_IDX_W = $clog2(NUM_FEAT_OUT);
  localparam int FIN_IDX_W  = $clog2(NUM_FEAT_FINAL);

  localparam logic [2:0] S_IDLE  = 3'd0;
  localparam logic [2:0] S_READ  = 3'd1;
  localparam logic [2:0] S_DRAIN = 3'd2;
  localparam logic [2:0] S_WRITE = 3'd3;
  localparam logic [2:0] S_DONE  = 3'd4;

  logic [2:0]                   state;
  logic [NODE_IDX_W-1:0]        node_idx;
  logic [FEAT_IDX_W-1:0]        feat_idx;
  logic [FEAT_IDX_W-1:0]        vld_idx;
  logic [FIN_IDX_W-1:0]         fin_idx;
  logic                         rd_vld;
  logic signed [DATA_WIDTH-1:0] feat_wgt [NUM_FEAT_FINAL];
  logic signed [OUT_WIDTH-1:0]  prod [NUM_FEAT_FINAL];
  logic signed [OUT_WIDTH-1:0]  acc [NUM_FEAT_FINAL];
  logic [OUT_WIDTH-1:0]         out_mem [OUT_DEPTH];
  logic                         out_wr_en;
  logic [OUT_ADDR_W-1:0]        out_wr_addr;

  // ========================================
  // Node sequencer
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= S_IDLE;
      node_idx    <= '0;
      feat_idx    <= '0;
      vld_idx     <= '0;
      fin_idx     <= '0;
      rd_vld      <= 1'b0;
      gat_ready_o <= 1'b0;
    end else begin
      rd_vld  <= (state == S_READ);
      vld_idx <= feat_idx;
      case (state)
        S_IDLE: begin
          if (l1_done_i) begin
            state <= S_READ;
          end
        end
        S_READ: begin
          feat_idx <= feat_idx + 1'b1;
          if (feat_idx == FEAT_IDX_W'(NUM_FEAT_OUT - 1)) begin
            state <= S_DRAIN;
          end
        end
        S_DRAIN: state <= S_WRITE;
        S_WRITE: begin
          fin_idx <= fin_idx + 1'b1;
          if (fin_idx == FIN_IDX_W'(NUM_FEAT_FINAL - 1)) begin
            if (node_idx == NODE_IDX_W'(NUM_NODES - 1)) begin
              state       <= S_DONE;
              gat_ready_o <= 1'b1;
            end else begin
              node_idx <= node_idx + 1'b1;
              state    <= S_READ;
            end
          end
        end
        default: ;
      endcase
    end
  end

  assign l2_rd_addr_o = FEAT_ADDR_W'(int'(node_idx) * NUM_FEAT_OUT + int'(feat_idx));

  // Features are unsigned, weights signed
  always_comb begin
    for (int f = 0; f < NUM_FEAT_FINAL; f++) begin
      feat_wgt[f] = w2_i[(int'(vld_idx) * NUM_FEAT_FINAL + f) * DATA_WIDTH +: DATA_WIDTH];
      prod[f]     = $signed({1'b0, node_rd_data_i.feat}) * feat_wgt[f];
    end
  end

  // First feature of a node restarts the sums
  always_ff @(posedge clk) begin
    if (rd_vld) begin
      for (int f = 0; f < NUM_FEAT_FINAL; f++) begin
        if (vld_idx == '0) begin
          acc[f] <= prod[f];
        end else begin
          acc[f] <= acc[f] + prod[f];
        end
      end
    end
  end

  // ========================================
  // Output memory
  // ========================================
  assign out_wr_en   = (state == S_WRITE);
  assign out_wr_addr = OUT_ADDR_W'(int'(node_idx) * NUM_FEAT_FINAL + int'(fin_idx));

  always_ff @(posedge clk) begin
    if (out_wr_en) begin
      out_mem[out_wr_addr] <= acc[fin_idx];
    end
    feat_rd_data_o <= out_mem[feat_rd_addr_i];
  end

  a_out_addr: assert property (@(posedge clk) disable iff (!rst_n)
    out_wr_en |-> (int'(node_idx) * NUM_FEAT_FINAL + int'(fin_idx) < OUT_DEPTH));

endmodule

/* design/gat_top.sv */
module gat_top
  import gat_pkg::*;
#(
  parameter int NUM_NODES   = 8,
  parameter int NNZ_DEPTH   = 64,
  localparam int NODE_DEPTH  = NNZ_DEPTH + NUM_NODES * NUM_FEAT_OUT,
  localparam int NODE_ADDR_W = $clog2(NODE_DEPTH),
  localparam int NODE_IDX_W  = $clog2(NUM_NODES),
  localparam int FEAT_ADDR_W = $clog2(NUM_NODES * NUM_FEAT_OUT),
  localparam int OUT_ADDR_W  = $clog2(NUM_NODES * NUM_FEAT_FINAL)
) (
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic                   wgt_wr_en_i,
  input  logic [WGT_ADDR_W-1:0]  wgt_addr_i,
  input  logic [DATA_WIDTH-1:0]  wgt_data_i,
  input  logic                   wgt_load_done_i,

  input  logic                   node_wr_en_i,
  input  logic [NODE_IDX_W-1:0]  node_addr_i,
  input  logic [ROW_LEN_W-1:0]   node_len_i,

  input  logic                   h_wr_en_i,
  input  logic [NODE_ADDR_W-1:0] h_addr_i,
  input  logic [NODE_WORD_W-1:0] h_data_i,
  input  logic                   h_load_done_i,

  input  logic [OUT_ADDR_W-1:0]  feat_rd_addr_i,
  output logic [OUT_WIDTH-1:0]   feat_rd_data_o,
  output logic                   gat_ready_o
);

  logic                   sched_rdy;
  logic [W1_BITS-1:0]     w1;
  logic [W2_BITS-1:0]     w2;

  logic [NODE_ADDR_W-1:0] l1_rd_addr;
  logic                   l1_wr_en;
  logic [NODE_ADDR_W-1:0] l1_wr_addr;
  node_word_u             l1_wr_data;
  logic                   l1_done;
  logic [FEAT_ADDR_W-1:0] l2_rd_addr;
  node_word_u             node_rd_data;

  // ========================================
  // Weight scheduler
  // ========================================
  weight_scheduler u_weight_scheduler (
    .clk             (clk),
    .rst_n           (rst_n),
    .wgt_wr_en_i     (wgt_wr_en_i),
    .wgt_addr_i      (wgt_addr_i),
    .wgt_data_i      (wgt_data_i),
    .wgt_load_done_i (wgt_load_done_i),
    .sched_rdy_o     (sched_rdy),
    .w1_o            (w1),
    .w2_o            (w2)
  );

  // ========================================
  // Shared node memory
  // ========================================
  node_mem_arbiter #(
    .NUM_NODES (NUM_NODES),
    .NNZ_DEPTH (NNZ_DEPTH)
  ) u_node_mem_arbiter (
    .clk            (clk),
    .rst_n          (rst_n),
    .h_wr_en_i      (h_wr_en_i),
    .h_addr_i       (h_addr_i),
    .h_data_i       (h_data_i),
    .l1_rd_addr_i   (l1_rd_addr),
    .l1_wr_en_i     (l1_wr_en),
    .l1_wr_addr_i   (l1_wr_addr),
    .l1_wr_data_i   (l1_wr_data),
    .l1_done_i      (l1_done),
    .l2_rd_addr_i   (l2_rd_addr),
    .node_rd_data_o (node_rd_data)
  );

  // ========================================
  // Layer engines
  // ========================================
  sparse_layer_engine #(
    .NUM_NODES (NUM_NODES),
    .NNZ_DEPTH (NNZ_DEPTH)
  ) u_sparse_layer_engine (
    .clk            (clk),
    .rst_n          (rst_n),
    .node_wr_en_i   (node_wr_en_i),
    .node_addr_i    (node_addr_i),
    .node_len_i     (node_len_i),
    .h_load_done_i  (h_load_done_i),
    .sched_rdy_i    (sched_rdy),
    .w1_i           (w1),
    .node_rd_data_i (node_rd_data),
    .l1_rd_addr_o   (l1_rd_addr),
    .l1_wr_en_o     (l1_wr_en),
    .l1_wr_addr_o   (l1_wr_addr),
    .l1_wr_data_o   (l1_wr_data),
    .l1_done_o      (l1_done)
  );

  dense_layer_engine #(
    .NUM_NODES (NUM_NODES)
  ) u_dense_layer_engine (
    .clk            (clk),
    .rst_n          (rst_n),
    .l1_done_i      (l1_done),
    .w2_i           (w2),
    .node_rd_data_i (node_rd_data),
    .feat_rd_addr_i (feat_rd_addr_i),
    .l2_rd_addr_o   (l2_rd_addr),
    .gat_ready_o    (gat_ready_o),
    .feat_rd_data_o (feat_rd_data_o)
  );

endmodule

/* verification/gat_tb.sv */
module gat_tb
  import gat_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_NODES  = 8;
  localparam int NNZ_DEPTH  = 64;
  localparam int OUT_DEPTH  = NUM_NODES * NUM_FEAT_FINAL;
  localparam int MAX_LEN    = 6;
  // Load ~200, layers ~250, readback ~50 cycles
  localparam int MAX_CYCLES = 2000;

  logic                   clk;
  logic                   rst_n;
  logic                   wgt_wr_en_i;
  logic [WGT_ADDR_W-1:0]  wgt_addr_i;
  logic [DATA_WIDTH-1:0]  wgt_data_i;
  logic                   wgt_load_done_i;
  logic                   node_wr_en_i;
  logic [2:0]             node_addr_i;
  logic [ROW_LEN_W-1:0]   node_len_i;
  logic                   h_wr_en_i;
  logic [6:0]             h_addr_i;
  logic [NODE_WORD_W-1:0] h_data_i;
  logic                   h_load_done_i;
  logic [3:0]             feat_rd_addr_i;
  logic [OUT_WIDTH-1:0]   feat_rd_data_o;
  logic                   gat_ready_o;

  logic [31:0]          lcg_state;
  int                   errors;
  int                   cycles;
  int                   neg_seen;
  int                   w1_m [NUM_FEAT_IN][NUM_FEAT_OUT];
  int                   w2_m [NUM_FEAT_OUT][NUM_FEAT_FINAL];
  int                   row_len [NUM_NODES];
  int                   row_col [NUM_NODES][MAX_LEN];
  int                   row_val [NUM_NODES][MAX_LEN];
  int                   feat_m [NUM_NODES][NUM_FEAT_OUT];
  logic [OUT_WIDTH-1:0] out_m [OUT_DEPTH];
  logic [OUT_WIDTH-1:0] got [OUT_DEPTH];

  gat_top #(
    .NUM_NODES (NUM_NODES),
    .NNZ_DEPTH (NNZ_DEPTH)
  ) gat_top_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .wgt_wr_en_i     (wgt_wr_en_i),
    .wgt_addr_i      (wgt_addr_i),
    .wgt_data_i      (wgt_data_i),
    .wgt_load_done_i (wgt_load_done_i),
    .node_wr_en_i    (node_wr_en_i),
    .node_addr_i     (node_addr_i),
    .node_len_i      (node_len_i),
    .h_wr_en_i       (h_wr_en_i),
    .h_addr_i        (h_addr_i),
    .h_data_i        (h_data_i),
    .h_load_done_i   (h_load_done_i),
    .feat_rd_addr_i  (feat_rd_addr_i),
    .feat_rd_data_o  (feat_rd_data_o),
    .gat_ready_o     (gat_ready_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Watchdog
  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("Verification failed");
    $finish;
  end

  a_ready_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    gat_ready_o |=> gat_ready_o)
    else begin
      $display("gat_ready_o dropped after it had risen");
      errors++;
    end

  function automatic int next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return int'(lcg_state[30:16]);
  endfunction

  function automatic int rand_signed();
    return (next_rand() % 256) - 128;
  endfunction

  // ========================================
  // Stimulus and reference model
  // ========================================
  task automatic build_stimulus();
    int picked;
    int len;
    for (int i = 0; i < NUM_FEAT_IN; i++) begin
      for (int o = 0; o < NUM_FEAT_OUT; o++) begin
        w1_m[i][o] = rand_signed();
      end
    end
    for (int f = 0; f < NUM_FEAT_OUT; f++) begin
      for (int k = 0; k < NUM_FEAT_FINAL; k++) begin
        w2_m[f][k] = rand_signed();
      end
    end
    for (int n = 0; n < NUM_NODES; n++) begin
      len = (n == 0) ? 0 : (n == 1) ? MAX_LEN : next_rand() % (MAX_LEN + 1);
      row_len[n] = len;
      picked = 0;
      // Selection sampling keeps columns distinct and increasing
      for (int c = 0; c < NUM_FEAT_IN; c++) begin
        if (picked < len && (next_rand() % (NUM_FEAT_IN - c)) < len - picked) begin
          row_col[n][picked] = c;
          row_val[n][picked] = rand_signed();
          picked++;
        end
      end
    end
    // Node 1 saturates, node 2 goes negative on the same columns
    for (int e = 0; e < MAX_LEN; e++) begin
      row_val[1][e] = 100 + next_rand() % 28;
      for (int o = 0; o < NUM_FEAT_OUT; o++) begin
        w1_m[row_col[1][e]][o] = 100 + next_rand() % 28;
      end
    end
    row_len[2] = 3;
    for (int e = 0; e < 3; e++) begin
      row_col[2][e] = row_col[1][e];
      row_val[2][e] = -100 - next_rand() % 28;
    end
  endtask

  task automatic compute_model();
    int sum;
    neg_seen = 0;
    for (int n = 0; n < NUM_NODES; n++) begin
      for (int o = 0; o < NUM_FEAT_OUT; o++) begin
        sum = 0;
        for (int e = 0; e < row_len[n]; e++) begin
          sum += row_val[n][e] * w1_m[row_col[n][e]][o];
        end
        if (sum < 0) begin
          neg_seen++;
        end
        feat_m[n][o] = (sum < 0) ? 0 : (sum > FEAT_MAX) ? FEAT_MAX : sum;
      end
      for (int k = 0; k < NUM_FEAT_FINAL; k++) begin
        sum = 0;
        for (int o = 0; o < NUM_FEAT_OUT; o++) begin
          sum += feat_m[n][o] * w2_m[o][k];
        end
        out_m[n * NUM_FEAT_FINAL + k] = OUT_WIDTH'(sum);
      end
    end
  endtask

  // ========================================
  // Host load
  // ========================================
  task automatic load_memories();
    int ptr;
    for (int a = 0; a < WGT_DEPTH; a++) begin
      @(posedge clk);
      wgt_wr_en_i <= 1'b1;
      wgt_addr_i  <= WGT_ADDR_W'(a);
      if (a < NUM_FEAT_IN * NUM_FEAT_OUT) begin
        wgt_data_i <= DATA_WIDTH'(w1_m[a / NUM_FEAT_OUT][a % NUM_FEAT_OUT]);
      end else begin
        wgt_data_i <= DATA_WIDTH'(w2_m[(a - 64) / NUM_FEAT_FINAL][(a - 64) % NUM_FEAT_FINAL]);
      end
    end
    @(posedge clk);
    wgt_wr_en_i <= 1'b0;
    ptr = 0;
    for (int n = 0; n < NUM_NODES; n++) begin
      @(posedge clk);
      node_wr_en_i <= 1'b1;
      node_addr_i  <= 3'(n);
      node_len_i   <= ROW_LEN_W'(row_len[n]);
      for (int e = 0; e < row_len[n]; e++) begin
        @(posedge clk);
        node_wr_en_i <= 1'b0;
        h_wr_en_i    <= 1'b1;
        h_addr_i     <= 7'(ptr);
        h_data_i     <= {COL_W'(row_col[n][e]), DATA_WIDTH'(row_val[n][e])};
        ptr++;
      end
      @(posedge clk);
      node_wr_en_i <= 1'b0;
      h_wr_en_i    <= 1'b0;
    end
  endtask

  // ========================================
  // Readback
  // ========================================
  // New address every cycle, data checked one cycle later
  task automatic read_stream();
    for (int a = 0; a <= OUT_DEPTH; a++) begin
      @(posedge clk);
      if (a < OUT_DEPTH) begin
        feat_rd_addr_i <= 4'(a);
      end
      @(negedge clk);
      if (a > 0) begin
        got[a - 1] = feat_rd_data_o;
        assert (feat_rd_data_o == out_m[a - 1])
          else begin
            $display("ERR feat_rd_data_o addr=%0h got=%h exp=%h",
                     a - 1, feat_rd_data_o, out_m[a - 1]);
            errors++;
          end
      end
    end
  endtask

  task automatic hold_read(input int addr);
    @(posedge clk);
    feat_rd_addr_i <= 4'(addr);
    repeat (3) begin
      @(posedge clk);
      @(negedge clk);
      assert (feat_rd_data_o == out_m[addr])
        else begin
          $display("ERR feat_rd_data_o addr=%0h got=%h exp=%h", addr, feat_rd_data_o,
                   out_m[addr]);
          errors++;
        end
    end
  endtask

  initial begin
    errors          = 0;
    lcg_state       = 32'd38807;
    rst_n           = 1'b0;
    wgt_wr_en_i     = 1'b0;
    wgt_addr_i      = '0;
    wgt_data_i      = '0;
    wgt_load_done_i = 1'b0;
    node_wr_en_i    = 1'b0;
    node_addr_i     = '0;
    node_len_i      = '0;
    h_wr_en_i       = 1'b0;
    h_addr_i        = '0;
    h_data_i        = '0;
    h_load_done_i   = 1'b0;
    feat_rd_addr_i  = '0;

    build_stimulus();
    compute_model();
    assert (feat_m[1][0] == FEAT_MAX && feat_m[1][3] == FEAT_MAX)
      else begin
        $display("Node 1 stimulus does not reach the feature clamp");
        errors++;
      end
    assert (neg_seen > 0)
      else begin
        $display("No negative first-layer sum in the stimulus");
        errors++;
      end

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (!gat_ready_o)
      else begin
        $display("gat_ready_o is high right after reset");
        errors++;
      end

    load_memories();
    @(posedge clk);
    wgt_load_done_i <= 1'b1;
    h_load_done_i   <= 1'b1;
    while (!gat_ready_o) begin
      @(posedge clk);
    end

    read_stream();
    hold_read(2);
    hold_read(11);

    // Empty row and all-negative row both give zero outputs
    assert (got[0] == '0 && got[1] == '0)
      else begin
        $display("ERR feat_rd_data_o node0 got=%h,%h exp=0", got[0], got[1]);
        errors++;
      end
    assert (got[4] == '0 && got[5] == '0)
      else begin
        $display("ERR feat_rd_data_o node2 got=%h,%h exp=0", got[4], got[5]);
        errors++;
      end

    $display("Run complete after %0d cycles, errors: %0d", cycles, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* sources.f */
design/gat_pkg.sv
design/weight_scheduler.sv
design/node_mem_arbiter.sv
design/sparse_layer_engine.sv
design/dense_layer_engine.sv
design/gat_top.sv
verification/gat_tb.sv

/* Bender.yml */
package:
  name: gat_accel

sources:
  - files:
      - design/gat_pkg.sv
      - design/weight_scheduler.sv
      - design/node_mem_arbiter.sv
      - design/sparse_layer_engine.sv
      - design/dense_layer_engine.sv
      - design/gat_top.sv
  - target: test
    files:
      - verification/gat_tb.sv
